//--- logic/mem_pkg.sv
// Word addressing only, bit 0 must be zero; banks are interleaved on word address bits [2:1]
`default_nettype none

package mem_pkg;

   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 16;
   localparam int NUM_BANKS   = 4;
   localparam int BANK_W      = 2;
   localparam int ROW_W       = 13;
   localparam int MEM_LATENCY = 4;

   // Address seen by the cache
   typedef struct packed {
      logic [4:0] tag;
      logic [7:0] index;
      logic [1:0] offset;
      logic       byte_sel;
   } cache_view_t;

   // Same address seen by main memory
   // Bank takes the word offset bits, so one line covers all four banks
   typedef struct packed {
      logic [ROW_W-1:0]  row;
      logic [BANK_W-1:0] bank;
      logic              byte_sel;
   } mem_view_t;

   typedef union packed {
      cache_view_t c;
      mem_view_t   m;
   } addr_u;

   // One word request toward the banks, 33 bits
   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ROW_W-1:0]  row;
      logic [BANK_W-1:0] bank;
      logic [DATA_W-1:0] wdata;
   } bank_req_t;

   // Read return, pos is the word position inside the line
   typedef struct packed {
      logic              valid;
      logic [BANK_W-1:0] pos;
      logic [DATA_W-1:0] rdata;
   } bank_rsp_t;

endpackage

`default_nettype wire

//--- logic/cache_pkg.sv
// Cache geometry must agree with the tag, index and offset fields of mem_pkg::addr_u
`default_nettype none

package cache_pkg;

   localparam int CACHE_LINES    = 256;
   localparam int WORDS_PER_LINE = 4;
   localparam int TAG_W          = 5;

   // Miss handling steps of the controller
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WB_ISSUE,
      WB_WAIT,
      FILL_ISSUE,
      FILL_WAIT,
      FINISH,
      ERROR
   } ctrl_state_e;

   // Lookup result for the indexed line, 8 bits
   typedef struct packed {
      logic             hit;
      logic             valid;
      logic             dirty;
      logic [TAG_W-1:0] victim_tag;
   } line_status_t;

   // hit is only meaningful while compare is asserted
   // victim_tag is the stored tag, used to rebuild
   // the write-back address of a dirty line

endpackage

`default_nettype wire

//--- logic/cache_array.sv
// Data and tags have no reset, only valid and dirty clear; reads are combinational
`timescale 1ns/1ps
`default_nettype none

module cache_array
   import mem_pkg::*;
   import cache_pkg::*;
(
   input  wire                                 clk,
   input  wire                                 arst_n,
   input  wire addr_u                          addr,
   input  wire [DATA_W-1:0]                    data_in,
   input  wire                                 compare,
   input  wire                                 write,
   input  wire                                 fill,
   input  wire                                 clean,
   input  wire [$clog2(WORDS_PER_LINE)-1:0]    fill_pos,
   output line_status_t                        status,
   output logic [DATA_W-1:0]                   data_out
);

   logic [TAG_W-1:0]  tag_mem  [CACHE_LINES];
   logic [DATA_W-1:0] data_mem [CACHE_LINES][WORDS_PER_LINE];
   logic [CACHE_LINES-1:0] valid_q;
   logic [CACHE_LINES-1:0] dirty_q;

   logic             line_valid;
   logic [TAG_W-1:0] line_tag;

   assign line_valid = valid_q[addr.c.index];
   assign line_tag   = tag_mem[addr.c.index];

   // Lookup of the indexed line
   always_comb begin
      status.valid      = line_valid;
      status.dirty      = dirty_q[addr.c.index];
      status.victim_tag = line_tag;
      status.hit        = compare & line_valid & (line_tag == addr.c.tag);
   end

   assign data_out = data_mem[addr.c.index][addr.c.offset];

   // Line state bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill) begin
         // Freshly filled line matches memory
         valid_q[addr.c.index] <= 1'b1;
         dirty_q[addr.c.index] <= 1'b0;
      end else if (write) begin
         dirty_q[addr.c.index] <= 1'b1;
      end else if (clean) begin
         dirty_q[addr.c.index] <= 1'b0;
      end
   end

   // Tag and word storage
   always_ff @(posedge clk) begin
      if (fill) begin
         tag_mem[addr.c.index]            <= addr.c.tag;
         data_mem[addr.c.index][fill_pos] <= data_in;
      end else if (write) begin
         data_mem[addr.c.index][addr.c.offset] <= data_in;
      end
   end

   // Fill writes the returned word at fill_pos, not at the
   // requester offset, since words come back one per bank
   // and the requester address stays fixed during the miss.
   // The requested write itself is applied afterwards by the
   // controller with a second compare.

endmodule

`default_nettype wire

//--- logic/bank_dispatch.sv
// Combinational; a request to a busy bank is never forwarded, the sender must hold it
`timescale 1ns/1ps
`default_nettype none

module bank_dispatch
   import mem_pkg::*;
(
   input  wire bank_req_t            req,
   input  wire [NUM_BANKS-1:0]       bank_busy,
   output bank_req_t                 bank_req [NUM_BANKS],
   output logic                      conflict
);

   logic target_busy;

   assign target_busy = bank_busy[req.bank];

   // Target bank still working on an earlier access
   assign conflict = req.valid & target_busy;

   // Every bank sees the payload, only the target gets valid
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_req[b]       = req;
         bank_req[b].valid = req.valid & ~target_busy & (req.bank == BANK_W'(b));
      end
   end

   // No queueing here
   // A blocked request simply stays on req until the bank
   // drops busy, so ordering across banks is decided by the
   // sender alone.

endmodule

`default_nettype wire

//--- logic/mem_bank.sv
// Behavioral bank; contents undefined after power-up, no request may arrive while busy
`timescale 1ns/1ps
`default_nettype none

module mem_bank
   import mem_pkg::*;
(
   input  wire            clk,
   input  wire            arst_n,
   input  wire bank_req_t req,
   output logic           busy,
   output bank_rsp_t      rsp
);

   logic [DATA_W-1:0] mem [2**ROW_W];

   logic [MEM_LATENCY-1:0]             pipe_vld;
   logic [MEM_LATENCY-1:0][BANK_W-1:0] pipe_pos;
   logic [DATA_W-1:0]                  rdata_q;
   logic [$clog2(MEM_LATENCY+1)-1:0]   busy_cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pipe_vld <= '0;
         busy_cnt <= '0;
      end else begin
         pipe_vld <= {pipe_vld[MEM_LATENCY-2:0], req.valid & ~req.we};
         if (req.valid) begin
            busy_cnt <= $bits(busy_cnt)'(MEM_LATENCY);
         end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
         end
      end
   end

   // Word position equals the bank number with word interleaving
   always_ff @(posedge clk) begin
      pipe_pos <= {pipe_pos[MEM_LATENCY-2:0], req.bank};
      if (req.valid) begin
         if (req.we) begin
            mem[req.row] <= req.wdata;
         end else begin
            rdata_q <= mem[req.row];
         end
      end
   end

   assign busy = (busy_cnt != '0);

   // One data register is enough while busy blocks new reads
   assign rsp = '{valid: pipe_vld[MEM_LATENCY-1], pos: pipe_pos[MEM_LATENCY-1], rdata: rdata_q};

endmodule

`default_nettype wire

//--- logic/bank_collect.sv
// Expects at most one valid return per cycle; on a collision the lowest bank wins
`timescale 1ns/1ps
`default_nettype none

module bank_collect
   import mem_pkg::*;
(
   input  wire bank_rsp_t bank_rsp [NUM_BANKS],
   output bank_rsp_t      rsp
);

   // Scan from the top so the lowest valid bank is kept last
   always_comb begin
      rsp = '0;
      for (int b = NUM_BANKS - 1; b >= 0; b--) begin
         if (bank_rsp[b].valid) begin
            rsp = bank_rsp[b];
         end
      end
   end

   // In-order issue to interleaved banks spaces the
   // returns one cycle apart, so the scan above is only a
   // merge in normal use.
   // A second valid in the same cycle means the issue
   // order was broken upstream and that word is dropped.
   // The word position travels with the data, so the
   // controller does not track which bank answered.

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
// Requester must hold addr, rd and wr until done; one request in flight at a time
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
   import mem_pkg::*;
   import cache_pkg::*;
(
   input  wire                                 clk,
   input  wire                                 arst_n,
   input  wire addr_u                          addr,
   input  wire                                 rd,
   input  wire                                 wr,
   input  wire line_status_t                   status,
   input  wire                                 conflict,
   input  wire bank_rsp_t                      fill_rsp,
   output logic                                compare,
   output logic                                write,
   output logic                                fill,
   output logic                                clean,
   output logic [$clog2(WORDS_PER_LINE)-1:0]   fill_pos,
   output bank_req_t                           mem_req,
   output logic                                evict_data_sel,
   output logic                                done,
   output logic                                cache_hit,
   output logic                                err
);

   ctrl_state_e state_q;
   ctrl_state_e state_d;

   logic [$clog2(WORDS_PER_LINE)-1:0] issue_cnt_q;
   logic [$clog2(WORDS_PER_LINE)-1:0] ret_cnt_q;
   logic                              hit_q;
   logic                              bad_req;
   logic [TAG_W-1:0]                  line_tag;
   addr_u                             mem_addr;

   // Odd address or both strobes is refused without any access
   assign bad_req = addr.c.byte_sel | (rd & wr);

   // Write-back goes to the victim's address, fill to the requested one
   assign line_tag = (state_q == WB_ISSUE) ? status.victim_tag : addr.c.tag;
   assign mem_addr = {line_tag, addr.c.index, issue_cnt_q, 1'b0};

   assign evict_data_sel = (state_q == WB_ISSUE);
   assign fill           = fill_rsp.valid;
   assign fill_pos       = evict_data_sel ? issue_cnt_q : fill_rsp.pos;
   assign clean          = (state_q == WB_WAIT);

   // Write data is taken from the cache at the top level
   always_comb begin
      mem_req       = '0;
      mem_req.valid = (state_q == WB_ISSUE) | (state_q == FILL_ISSUE);
      mem_req.we    = (state_q == WB_ISSUE);
      mem_req.row   = mem_addr.m.row;
      mem_req.bank  = mem_addr.m.bank;
   end

   always_comb begin
      state_d = state_q;
      compare = 1'b0;
      write   = 1'b0;
      case (state_q)
         IDLE: begin
            if (rd | wr) begin
               if (bad_req) begin
                  state_d = ERROR;
               end else begin
                  compare = 1'b1;
                  if (status.hit) begin
                     write   = wr;
                     state_d = FINISH;
                  end else if (status.valid & status.dirty) begin
                     state_d = WB_ISSUE;
                  end else begin
                     state_d = FILL_ISSUE;
                  end
               end
            end
         end
         WB_ISSUE: begin
            if (!conflict && issue_cnt_q == '1) begin
               state_d = WB_WAIT;
            end
         end
         WB_WAIT: state_d = FILL_ISSUE;
         FILL_ISSUE: begin
            if (!conflict && issue_cnt_q == '1) begin
               state_d = FILL_WAIT;
            end
         end
         FILL_WAIT: begin
            if (fill_rsp.valid && ret_cnt_q == '1) begin
               state_d = COMPARE;
            end
         end
         // Line is present now, apply the pending write
         COMPARE: begin
            compare = 1'b1;
            write   = wr;
            state_d = FINISH;
         end
         FINISH:  state_d = IDLE;
         ERROR:   state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q     <= IDLE;
         issue_cnt_q <= '0;
         ret_cnt_q   <= '0;
         hit_q       <= 1'b0;
      end else begin
         state_q <= state_d;
         // Advance only when the bank took the word
         if (mem_req.valid && !conflict) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
         end
         if (fill_rsp.valid) begin
            ret_cnt_q <= ret_cnt_q + 1'b1;
         end
         if (state_q == IDLE) begin
            hit_q <= status.hit;
         end
      end
   end

   assign done      = (state_q == FINISH) | (state_q == ERROR);
   assign cache_hit = (state_q == FINISH) & hit_q;
   assign err       = (state_q == ERROR);

endmodule

`default_nettype wire

//--- logic/mem_system.sv
// Requester interface only; main memory starts undefined, read only what was written
`timescale 1ns/1ps
`default_nettype none

module mem_system
   import mem_pkg::*;
   import cache_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n,
   input  wire [ADDR_W-1:0]  addr,
   input  wire [DATA_W-1:0]  data_in,
   input  wire               rd,
   input  wire               wr,
   output logic [DATA_W-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   addr_u        req_addr;
   addr_u        cache_addr;
   line_status_t status;
   logic         compare;
   logic         write;
   logic         fill;
   logic         clean;
   logic         evict_data_sel;
   logic         conflict;
   logic [$clog2(WORDS_PER_LINE)-1:0] fill_pos;
   logic [DATA_W-1:0]    cache_din;
   logic [DATA_W-1:0]    cache_rdata;
   logic [NUM_BANKS-1:0] bank_busy;
   bank_req_t mem_req;
   bank_req_t disp_req;
   bank_req_t bank_req [NUM_BANKS];
   bank_rsp_t bank_rsp [NUM_BANKS];
   bank_rsp_t fill_rsp;

   assign req_addr = addr;

   // Victim words are read out one by one during write-back
   assign cache_addr = evict_data_sel ?
                       {req_addr.c.tag, req_addr.c.index, fill_pos, 1'b0} : req_addr;
   assign cache_din  = fill ? fill_rsp.rdata : data_in;
   assign disp_req   = '{valid: mem_req.valid, we: mem_req.we, row: mem_req.row,
                         bank: mem_req.bank, wdata: cache_rdata};

   assign data_out = cache_rdata;
   assign stall    = (rd | wr) & ~done;

   cache_array cache_array_i (
      .clk, .arst_n, .addr(cache_addr), .data_in(cache_din), .compare, .write,
      .fill, .clean, .fill_pos, .status, .data_out(cache_rdata)
   );

   cache_ctrl cache_ctrl_i (
      .clk, .arst_n, .addr(req_addr), .rd, .wr, .status, .conflict, .fill_rsp,
      .compare, .write, .fill, .clean, .fill_pos, .mem_req, .evict_data_sel,
      .done, .cache_hit, .err
   );

   bank_dispatch bank_dispatch_i (
      .req(disp_req), .bank_busy, .bank_req, .conflict
   );

   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      mem_bank mem_bank_i (
         .clk, .arst_n, .req(bank_req[g]), .busy(bank_busy[g]), .rsp(bank_rsp[g])
      );
   end

   bank_collect bank_collect_i (
      .bank_rsp, .rsp(fill_rsp)
   );

endmodule

`default_nettype wire

//--- tests/tb_mem_system.sv
// Reads only addresses written earlier in the run; each wait for done gives up after WAIT_LIMIT
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system
   import mem_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   localparam int RAND_OPS   = 300;
   localparam int RAND_WORDS = 64;

   // Flags sampled in the done cycle
   typedef struct packed {
      logic cache_hit;
      logic err;
   } done_flags_t;

   logic              clk;
   logic              arst_n;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [DATA_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   // Reference model for the random phase
   logic [DATA_W-1:0] ref_mem [RAND_WORDS];
   logic              ref_written [RAND_WORDS];

   mem_system mem_system_i (
      .clk, .arst_n, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("MISMATCH at time %0t: %s gave %h, expected %h",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_flags(input string what, input done_flags_t got, input done_flags_t exp);
      if (got !== exp) begin
         stop_run($sformatf("MISMATCH at time %0t: %s flags hit=%b err=%b, expected hit=%b err=%b",
                            $time, what, got.cache_hit, got.err, exp.cache_hit, exp.err));
      end
   endtask

   task automatic check_level(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_cycles(input string what, input int got, input int lo, input int hi);
      if (got < lo || got > hi) begin
         stop_run($sformatf("MISMATCH at time %0t: %s took %0d cycles, expected %0d to %0d",
                            $time, what, got, lo, hi));
      end
   endtask

   function automatic done_flags_t flags_of(input logic hit, input logic e);
      done_flags_t f;
      f.cache_hit = hit;
      f.err       = e;
      return f;
   endfunction

   // Word address from tag, index and word offset, byte bit zero
   function automatic logic [ADDR_W-1:0] line_addr(input logic [4:0] tag, input logic [7:0] index,
                                                   input logic [1:0] offset);
      return {tag, index, offset, 1'b0};
   endfunction

   // One request, held until done, with stall checked every cycle
   task automatic access(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                         input logic r, input logic w, output logic [DATA_W-1:0] q,
                         output done_flags_t f, output int cycles);
      cycles = 0;
      @(posedge clk);
      #1;
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      @(negedge clk);
      while (!done) begin
         check_level("stall before done", stall, 1'b1);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            stop_run($sformatf("Timeout: done never came for the request to address %h", a));
         end
         @(negedge clk);
      end
      q = data_out;
      f = flags_of(cache_hit, err);
      check_level("stall with done", stall, 1'b0);
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      check_level("stall when idle", stall, 1'b0);
      check_level("done when idle", done, 1'b0);
   endtask

   task automatic test_write_read();
      logic [DATA_W-1:0] q;
      done_flags_t       f;
      int                n;
      access(line_addr(5'd0, 8'h24, 2'd0), 16'hbeef, 1'b0, 1'b1, q, f, n);
      check_flags("cold write", f, flags_of(1'b0, 1'b0));
      access(line_addr(5'd0, 8'h24, 2'd0), 16'h0000, 1'b1, 1'b0, q, f, n);
      check_word("read after write", q, 16'hbeef);
      check_flags("read after write", f, flags_of(1'b1, 1'b0));
   endtask

   task automatic test_line_hits();
      logic [DATA_W-1:0] q;
      done_flags_t       f;
      int                n;
      access(line_addr(5'd1, 8'h30, 2'd0), 16'h1111, 1'b0, 1'b1, q, f, n);
      check_flags("first word of new line", f, flags_of(1'b0, 1'b0));
      access(line_addr(5'd1, 8'h30, 2'd2), 16'h2222, 1'b0, 1'b1, q, f, n);
      check_flags("second word of same line", f, flags_of(1'b1, 1'b0));
      access(line_addr(5'd1, 8'h30, 2'd0), 16'h0000, 1'b1, 1'b0, q, f, n);
      check_word("word 0 of line", q, 16'h1111);
      check_flags("word 0 of line", f, flags_of(1'b1, 1'b0));
      access(line_addr(5'd1, 8'h30, 2'd2), 16'h0000, 1'b1, 1'b0, q, f, n);
      check_word("word 2 of line", q, 16'h2222);
   endtask

   // Same index, two tags, so each miss evicts a dirty line
   task automatic test_dirty_evict();
      logic [DATA_W-1:0] q;
      done_flags_t       f;
      int                n;
      access(line_addr(5'd3, 8'h40, 2'd1), 16'ha5a5, 1'b0, 1'b1, q, f, n);
      access(line_addr(5'd9, 8'h40, 2'd1), 16'h5a5a, 1'b0, 1'b1, q, f, n);
      check_flags("write to conflicting tag", f, flags_of(1'b0, 1'b0));
      access(line_addr(5'd3, 8'h40, 2'd1), 16'h0000, 1'b1, 1'b0, q, f, n);
      check_word("refill of evicted line", q, 16'ha5a5);
      check_flags("refill of evicted line", f, flags_of(1'b0, 1'b0));
      access(line_addr(5'd9, 8'h40, 2'd1), 16'h0000, 1'b1, 1'b0, q, f, n);
      check_word("second refill", q, 16'h5a5a);
      check_flags("second refill", f, flags_of(1'b0, 1'b0));
   endtask

   task automatic test_errors();
      logic [DATA_W-1:0] q;
      logic [ADDR_W-1:0] x;
      done_flags_t       f;
      int                n;
      x = line_addr(5'd2, 8'h11, 2'd2);
      access(x, 16'h1234, 1'b0, 1'b1, q, f, n);
      access(x | 16'd1, 16'hffff, 1'b0, 1'b1, q, f, n);
      check_flags("odd address write", f, flags_of(1'b0, 1'b1));
      check_cycles("odd address write", n, 1, 1);
      access(x | 16'd1, 16'h0000, 1'b1, 1'b0, q, f, n);
      check_flags("odd address read", f, flags_of(1'b0, 1'b1));
      access(x, 16'heeee, 1'b1, 1'b1, q, f, n);
      check_flags("read and write together", f, flags_of(1'b0, 1'b1));
      access(x, 16'h0000, 1'b1, 1'b0, q, f, n);
      check_word("word after refused requests", q, 16'h1234);
      check_flags("word after refused requests", f, flags_of(1'b1, 1'b0));
   endtask

   task automatic test_stall();
      logic [DATA_W-1:0] q;
      done_flags_t       f;
      int                n;
      repeat (3) begin
         @(negedge clk);
         check_level("stall with no request", stall, 1'b0);
      end
      access(line_addr(5'd4, 8'h55, 2'd3), 16'h7e57, 1'b0, 1'b1, q, f, n);
      check_cycles("clean miss", n, MEM_LATENCY + 1, WAIT_LIMIT);
      access(line_addr(5'd4, 8'h55, 2'd3), 16'h0000, 1'b1, 1'b0, q, f, n);
      check_cycles("read hit", n, 1, 1);
      check_word("read hit after miss", q, 16'h7e57);
   endtask

   // Tags 16 to 19 over indexes 0 to 3 force frequent evictions
   task automatic test_random();
      logic [DATA_W-1:0] q;
      logic [ADDR_W-1:0] a;
      logic [5:0]        slot;
      done_flags_t       f;
      int                n;
      int unsigned       r;
      for (int i = 0; i < RAND_OPS; i++) begin
         r    = $urandom;
         slot = r[5:0];
         a    = line_addr({3'b100, slot[5:4]}, {6'd0, slot[3:2]}, slot[1:0]);
         if (r[6] || !ref_written[slot]) begin
            access(a, r[31:16], 1'b0, 1'b1, q, f, n);
            ref_mem[slot]     = r[31:16];
            ref_written[slot] = 1'b1;
         end else begin
            access(a, 16'h0000, 1'b1, 1'b0, q, f, n);
            check_word($sformatf("random read of %h", a), q, ref_mem[slot]);
         end
         check_level("err on random access", f.err, 1'b0);
      end
   endtask

   initial begin
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      arst_n  = 1'b0;
      void'($urandom(32'h8367));
      for (int i = 0; i < RAND_WORDS; i++) begin
         ref_mem[i]     = '0;
         ref_written[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_level("done after reset", done, 1'b0);
      check_level("stall after reset", stall, 1'b0);
      check_level("cache_hit after reset", cache_hit, 1'b0);
      check_level("err after reset", err, 1'b0);
      test_write_read();
      test_line_hits();
      test_dirty_evict();
      test_errors();
      test_stall();
      test_random();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
logic/mem_pkg.sv
logic/cache_pkg.sv
logic/cache_array.sv
logic/bank_dispatch.sv
logic/mem_bank.sv
logic/bank_collect.sv
logic/cache_ctrl.sv
logic/mem_system.sv
tests/tb_mem_system.sv

//--- run.sh
#!/bin/sh
# Build and run the mem_system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   -f flist.f --top-module tb_mem_system -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
